//--- core.f
hw/core_pkg.sv
hw/decoder.sv
hw/regfile.sv
hw/execute.sv
hw/mem_access.sv
hw/hazard_ctrl.sv
hw/core.sv
+incdir+bench
bench/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the simulator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module core_tb -f core.f -o core_sim > build.log 2>&1 \
   && ./obj_dir/core_sim > sim.log 2>&1 \
   || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -qF "*** TEST PASSED ***" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

//--- bench/core_tb_tests.svh
`ifndef CORE_TB_TESTS_SVH
`define CORE_TB_TESTS_SVH

////////////////////////////////////////
// instruction encoders
////////////////////////////////////////

function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                input int rd);
   return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic word_t enc_i(input word_t imm, input int rs1, input int f3, input int rd,
                                input int op);
   return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t enc_s(input word_t imm, input int rs2, input int rs1);
   return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic word_t enc_b(input word_t imm, input int rs2, input int rs1, input int f3);
   return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic word_t enc_j(input word_t imm, input int rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

function automatic word_t lcg_next();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return lcg_state;
endfunction

////////////////////////////////////////
// reference rules of RV32I
////////////////////////////////////////

function automatic word_t alu_ref(input int f3, input bit alt, input word_t a, input word_t b);
   case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return {31'b0, $signed(a) < $signed(b)};
      3: return {31'b0, a < b};
      4: return a ^ b;
      5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6: return a | b;
      default: return a & b;
   endcase
endfunction

function automatic bit cond_ref(input int f3, input word_t a, input word_t b);
   case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
   endcase
endfunction

////////////////////////////////////////
// program building
////////////////////////////////////////

function automatic word_t cur_pc();
   return RESET_PC + word_t'(prog_len * 4);
endfunction

task automatic emit(input word_t instr);
   rom[prog_len] = instr;
   prog_len++;
endtask

// empty slots jump to themselves
task automatic clear_program();
   for (int i = 0; i < 256; i++) begin
      rom[i] = enc_j('0, 0);
   end
   prog_len = 0;
   exp_kind.delete();
   exp_addr.delete();
   exp_data.delete();
endtask

task automatic emit_li(input int rd, input word_t value);
   word_t hi;
   hi = (value + 32'h800) & 32'hfffff000;
   emit({hi[31:12], rd[4:0], 7'h37});
   emit(enc_i(value, rd, 0, rd, 32'h13));
endtask

task automatic emit_sw(input int rs2, input word_t addr, input word_t value);
   emit(enc_s(addr, rs2, 0));
   exp_kind.push_back(KIND_STORE);
   exp_addr.push_back(addr);
   exp_data.push_back(value);
endtask

// value is what the ram holds at addr when the load runs
task automatic emit_lw(input int rd, input word_t addr, input word_t value);
   emit(enc_i(addr, 0, 2, rd, 32'h03));
   exp_kind.push_back(KIND_LOAD);
   exp_addr.push_back(addr);
   exp_data.push_back(value);
endtask

// final store to the sentinel word, then release reset
task automatic start_program();
   emit(enc_s(32'h7fc, 0, 0));
   @(posedge clk);
   rstn <= 1'b1;
   repeat (10) @(posedge clk);
   log_kind.delete();
   log_addr.delete();
   log_data.delete();
   rstn <= 1'b0;
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic test_reset_first_store();
   clear_program();
   emit_sw(0, 32'h0, 32'h0);
   start_program();
   // fetch, decode, then execute drives the store
   @(negedge clk);
   check_word(rom_addr, RESET_PC, "rom address after reset");
   check_word({31'b0, ram_we}, 32'd0, "ram_we in fetch cycle");
   check_word({31'b0, ram_en}, 32'd0, "ram_en in fetch cycle");
   @(negedge clk);
   check_word({31'b0, ram_we}, 32'd0, "ram_we in decode cycle");
   check_word({31'b0, ram_en}, 32'd0, "ram_en in decode cycle");
   @(negedge clk);
   check_word({31'b0, ram_we}, 32'd1, "ram_we in execute cycle");
   check_word({31'b0, ram_en}, 32'd1, "ram_en in execute cycle");
   wait_done("reset test");
   compare_log("reset test");
endtask

task automatic test_alu_forwarding();
   int    rf3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
   bit    ralt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
   int    if3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
   bit    ialt [9] = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
   word_t a;
   word_t b;
   word_t imm;
   word_t r;
   int    j;
   clear_program();
   for (int i = 0; i < 10; i++) begin
      a = lcg_next();
      b = lcg_next();
      j = i % 9;
      if (if3[j] == 1 || if3[j] == 5) begin
         imm = (lcg_next() & 32'h1f) | (ialt[j] ? 32'h400 : 32'h0);
      end else begin
         imm = lcg_next() & 32'hfff;
         imm = {{20{imm[11]}}, imm[11:0]};
      end
      r = alu_ref(rf3[i], ralt[i], a, b);
      emit_li(1, a);
      emit_li(2, b);
      emit(enc_r(ralt[i] ? 32'h20 : 32'h0, 2, 1, rf3[i], 3));
      emit(enc_i(imm, 3, if3[j], 4, 32'h13));
      emit_sw(3, 32'h100 + word_t'(8 * i), r);
      emit_sw(4, 32'h104 + word_t'(8 * i), alu_ref(if3[j], ialt[j], r, imm));
   end
   start_program();
   wait_done("alu test");
   compare_log("alu test");
endtask

task automatic test_load_use();
   word_t v;
   word_t d;
   clear_program();
   v = lcg_next();
   d = lcg_next();
   emit_li(8, d);
   emit_li(5, v);
   emit_sw(5, 32'h200, v);
   emit_lw(6, 32'h200, v);
   emit(enc_r(0, 8, 6, 0, 7));
   emit_sw(7, 32'h204, v + d);
   // load feeding the store data directly
   emit_lw(6, 32'h200, v);
   emit_sw(6, 32'h208, v);
   start_program();
   wait_done("load-use test");
   compare_log("load-use test");
endtask

task automatic test_jumps();
   word_t jal_pc;
   word_t jalr_pc;
   clear_program();
   emit_li(9, 32'h00dead00);
   jal_pc = cur_pc();
   emit(enc_j(32'd12, 1));
   emit(enc_s(32'h300, 9, 0));
   emit(enc_s(32'h304, 9, 0));
   emit_sw(1, 32'h310, jal_pc + 32'd4);
   jalr_pc = cur_pc() + 32'd8;
   emit_li(2, jalr_pc + 32'd12);
   emit(enc_i('0, 2, 0, 3, 32'h67));
   emit(enc_s(32'h308, 9, 0));
   emit(enc_s(32'h30c, 9, 0));
   emit_sw(3, 32'h314, jalr_pc + 32'd4);
   start_program();
   wait_done("jump test");
   compare_log("jump test");
endtask

task automatic test_branches();
   int    cf3 [6] = '{0, 1, 4, 5, 6, 7};
   word_t a;
   word_t b;
   word_t x;
   word_t y;
   word_t base;
   int    k;
   clear_program();
   emit_li(11, 32'h00000a11);
   emit_li(12, 32'h00000b12);
   k = 0;
   for (int c = 0; c < 6; c++) begin
      a = lcg_next() | 32'h80000000;
      b = lcg_next() & 32'h7fffffff;
      for (int p = 0; p < 3; p++) begin
         x = (p == 1) ? b : a;
         y = (p == 0) ? b : a;
         base = 32'h400 + word_t'(8 * k);
         emit_li(1, x);
         emit_li(2, y);
         emit(enc_b(32'd12, 2, 1, cf3[c]));
         if (cond_ref(cf3[c], x, y)) begin
            emit(enc_s(base, 11, 0));
            emit(enc_j(32'd8, 0));
            emit_sw(12, base + 32'd4, 32'h00000b12);
         end else begin
            emit_sw(11, base, 32'h00000a11);
            emit(enc_j(32'd8, 0));
            emit(enc_s(base + 32'd4, 12, 0));
         end
         k++;
      end
   end
   start_program();
   wait_done("branch test");
   compare_log("branch test");
endtask

`endif

//--- bench/core_tb.sv
module core_tb;
   import core_pkg::*;

   localparam word_t RESET_PC   = '0;
   localparam int    RAM_ADDR_W = 19;
   localparam int    NUM_TESTS  = 5;
   localparam int    DONE_LIMIT = 350;
   localparam logic [RAM_ADDR_W-1:0] SENTINEL = 19'h1ff;

   logic                  clk;
   logic                  rstn;
   word_t                 rom_addr;
   word_t                 rom_data;
   logic [RAM_ADDR_W-1:0] ram_addr;
   word_t                 ram_din;
   logic                  ram_we;
   logic                  ram_en;
   word_t                 ram_dout;

   word_t rom [256];
   word_t ram [1024];
   int    prog_len;
   logic  done;
   int    errors;
   int    checks;
   word_t lcg_state;

   // ram accesses seen on the port and the ones the program should make
   op_kind_e log_kind [$];
   word_t    log_addr [$];
   word_t    log_data [$];
   op_kind_e exp_kind [$];
   word_t    exp_addr [$];
   word_t    exp_data [$];

   `include "core_tb_tests.svh"

   core #(
      .RESET_PC   (RESET_PC),
      .RAM_ADDR_W (RAM_ADDR_W)
   ) core_inst (
      .clk      (clk),
      .rstn     (rstn),
      .rom_addr (rom_addr),
      .rom_data (rom_data),
      .ram_addr (ram_addr),
      .ram_din  (ram_din),
      .ram_we   (ram_we),
      .ram_en   (ram_en),
      .ram_dout (ram_dout)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   ////////////////////////////////////////
   // memory models
   ////////////////////////////////////////

   // rom answers in the same cycle
   assign rom_data = rom[rom_addr[9:2]];

   always @(posedge clk) begin
      if (rstn) begin
         done <= 1'b0;
      end else if (ram_en) begin
         if (ram_we) begin
            ram[ram_addr[9:0]] <= ram_din;
            if (ram_addr == SENTINEL) begin
               done <= 1'b1;
            end else begin
               log_kind.push_back(KIND_STORE);
               log_addr.push_back({11'b0, ram_addr, 2'b00});
               log_data.push_back(ram_din);
            end
         end else begin
            ram_dout <= ram[ram_addr[9:0]];
            log_kind.push_back(KIND_LOAD);
            log_addr.push_back({11'b0, ram_addr, 2'b00});
            log_data.push_back(ram[ram_addr[9:0]]);
         end
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   task automatic check_word(input word_t actual, input word_t expected, input string msg);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      end
   endtask

   task automatic check_kind(input op_kind_e actual, input op_kind_e expected,
                             input string msg);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0t: %s, got %s, expected %s", $time, msg, actual.name(),
                  expected.name());
      end
   endtask

   task automatic compare_log(input string name);
      check_word(word_t'(log_addr.size()), word_t'(exp_addr.size()),
                 {name, " number of ram accesses"});
      for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
         check_kind(log_kind[i], exp_kind[i], {name, " access kind"});
         check_word(log_addr[i], exp_addr[i], {name, " access address"});
         check_word(log_data[i], exp_data[i], {name, " access data"});
      end
   endtask

   task automatic wait_done(input string name);
      int n;
      n = 0;
      while (!done && n < DONE_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (!done) begin
         errors++;
         $display("%s never reached its final store within %0d cycles", name, DONE_LIMIT);
      end
   endtask

   // runs past the sum of all test lengths
   initial begin
      repeat (NUM_TESTS * 400) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      rstn      = 1'b1;
      ram_dout  = '0;
      errors    = 0;
      checks    = 0;
      prog_len  = 0;
      lcg_state = 32'd23;
      for (int i = 0; i < 1024; i++) begin
         ram[i] = (word_t'(i) * 32'h9e3779b9) ^ 32'h5a5a0000;
      end
      test_reset_first_store();
      test_alu_forwarding();
      test_load_use();
      test_jumps();
      test_branches();
      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- hw/core.sv
module core #(
   parameter core_pkg::word_t RESET_PC   = '0,
   parameter int              RAM_ADDR_W = 19
) (
   input  logic                  clk,
   input  logic                  rstn,
   output core_pkg::word_t       rom_addr,
   input  core_pkg::word_t       rom_data,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output core_pkg::word_t       ram_din,
   output logic                  ram_we,
   output logic                  ram_en,
   input  core_pkg::word_t       ram_dout
);
   import core_pkg::*;

   // fetch/decode
   logic       fd_valid;
   word_t      fd_pc;
   word_t      fd_instr;

   // decode
   decoded_t   id_dec;
   word_t      rf_rd1;
   word_t      rf_rd2;
   operands_t  id_ops;
   fwd_sel_e   fwd_rs1;
   fwd_sel_e   fwd_rs2;
   logic       stall;
   logic       squash_fd;
   logic       squash_de;
   word_t      pc;

   // decode/execute
   logic       de_valid;
   decoded_t   de_dec;
   operands_t  de_ops;
   ex_result_t ex_res;

   // execute/memory
   logic       em_valid;
   ex_result_t em_res;
   word_t      mem_value;

   // memory/write-back
   logic       mw_valid;
   logic       mw_writes;
   reg_addr_t  mw_rd;
   word_t      mw_value;

   function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf_value,
                                     input word_t ex_value, input word_t mem_value_in);
      word_t v;
      case (sel)
         FWD_EX:  v = ex_value;
         FWD_MEM: v = mem_value_in;
         default: v = rf_value;
      endcase
      return v;
   endfunction

   assign rom_addr = pc;

   decoder decoder_inst (
      .pc        (fd_pc),
      .instr_raw (fd_instr),
      .dec       (id_dec)
   );

   regfile regfile_inst (
      .clk  (clk),
      .rstn (rstn),
      .rs1  (id_dec.rs1),
      .rs2  (id_dec.rs2),
      .rd1  (rf_rd1),
      .rd2  (rf_rd2),
      .we   (mw_valid && mw_writes),
      .wa   (mw_rd),
      .wd   (mw_value)
   );

   // write-back arrives through the regfile bypass
   assign id_ops.rs1 = fwd_mux(fwd_rs1, rf_rd1, ex_res.result, mem_value);
   assign id_ops.rs2 = fwd_mux(fwd_rs2, rf_rd2, ex_res.result, mem_value);

   hazard_ctrl #(
      .RESET_PC (RESET_PC)
   ) hazard_ctrl_inst (
      .clk          (clk),
      .rstn         (rstn),
      .id_dec       (id_dec),
      .id_valid     (fd_valid),
      .ex_res       (ex_res),
      .ex_valid     (de_valid),
      .mem_dec      (em_res.dec),
      .mem_valid    (em_valid),
      .id_rs1_value (id_ops.rs1),
      .fwd_rs1      (fwd_rs1),
      .fwd_rs2      (fwd_rs2),
      .stall        (stall),
      .squash_fd    (squash_fd),
      .squash_de    (squash_de),
      .pc           (pc)
   );

   execute execute_inst (
      .dec (de_dec),
      .ops (de_ops),
      .res (ex_res)
   );

   mem_access #(
      .RAM_ADDR_W (RAM_ADDR_W)
   ) mem_access_inst (
      .clk       (clk),
      .rstn      (rstn),
      .ex        (ex_res),
      .ex_valid  (de_valid),
      .mem_stage (em_res),
      .ram_addr  (ram_addr),
      .ram_din   (ram_din),
      .ram_we    (ram_we),
      .ram_en    (ram_en),
      .ram_dout  (ram_dout),
      .mem_value (mem_value)
   );

   ////////////////////////////////////////
   // pipeline registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         fd_valid <= 1'b0;
         de_valid <= 1'b0;
         em_valid <= 1'b0;
         mw_valid <= 1'b0;
      end else begin
         if (squash_fd) begin
            fd_valid <= 1'b0;
         end else if (!stall) begin
            fd_valid <= 1'b1;
         end
         // stall leaves a bubble behind the load
         de_valid <= fd_valid && !stall && !squash_de;
         em_valid <= de_valid;
         mw_valid <= em_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         fd_pc    <= pc;
         fd_instr <= rom_data;
      end
      de_dec    <= id_dec;
      de_ops    <= id_ops;
      em_res    <= ex_res;
      mw_rd     <= em_res.dec.rd;
      mw_writes <= em_res.dec.writes_rd;
      mw_value  <= mem_value;
   end

endmodule

//--- hw/hazard_ctrl.sv
module hazard_ctrl #(
   parameter core_pkg::word_t RESET_PC = '0
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  core_pkg::decoded_t   id_dec,
   input  logic                 id_valid,
   input  core_pkg::ex_result_t ex_res,
   input  logic                 ex_valid,
   input  core_pkg::decoded_t   mem_dec,
   input  logic                 mem_valid,
   input  core_pkg::word_t      id_rs1_value,
   output core_pkg::fwd_sel_e   fwd_rs1,
   output core_pkg::fwd_sel_e   fwd_rs2,
   output logic                 stall,
   output logic                 squash_fd,
   output logic                 squash_de,
   output core_pkg::word_t      pc
);
   import core_pkg::*;

   logic  ex_writes;
   logic  mem_writes;
   logic  ex_hit1;
   logic  ex_hit2;
   logic  mem_hit1;
   logic  mem_hit2;
   logic  id_jump;
   logic  redirect_id;
   logic  redirect_ex;
   word_t id_target;

   ////////////////////////////////////////
   // forwarding
   ////////////////////////////////////////

   assign ex_writes  = ex_valid && ex_res.dec.writes_rd;
   assign mem_writes = mem_valid && mem_dec.writes_rd;

   assign ex_hit1  = ex_writes && id_dec.uses_rs1 && (id_dec.rs1 == ex_res.dec.rd);
   assign ex_hit2  = ex_writes && id_dec.uses_rs2 && (id_dec.rs2 == ex_res.dec.rd);
   assign mem_hit1 = mem_writes && id_dec.uses_rs1 && (id_dec.rs1 == mem_dec.rd);
   assign mem_hit2 = mem_writes && id_dec.uses_rs2 && (id_dec.rs2 == mem_dec.rd);

   // youngest producer wins
   assign fwd_rs1 = ex_hit1 ? FWD_EX : (mem_hit1 ? FWD_MEM : FWD_RF);
   assign fwd_rs2 = ex_hit2 ? FWD_EX : (mem_hit2 ? FWD_MEM : FWD_RF);

   // load data not ready until the memory stage
   assign stall = id_valid && (ex_res.dec.kind == KIND_LOAD) && (ex_hit1 || ex_hit2);

   ////////////////////////////////////////
   // redirects
   ////////////////////////////////////////

   assign redirect_ex = ex_valid && ex_res.taken;
   assign id_jump     = (id_dec.kind == KIND_JAL) || (id_dec.kind == KIND_JALR);
   assign redirect_id = id_valid && id_jump && !stall && !redirect_ex;

   assign squash_fd = redirect_ex || redirect_id;
   assign squash_de = redirect_ex;

   assign id_target = (id_dec.kind == KIND_JALR) ? ((id_rs1_value + id_dec.imm) & ~32'd1)
                                                 : (id_dec.pc + id_dec.imm);

   always_ff @(posedge clk) begin
      if (rstn) begin
         pc <= RESET_PC;
      end else if (redirect_ex) begin
         pc <= ex_res.target;
      end else if (stall) begin
         pc <= pc;
      end else if (redirect_id) begin
         pc <= id_target;
      end else begin
         pc <= pc + 32'd4;
      end
   end

   no_stall_on_branch: assert property (@(posedge clk) disable iff (rstn)
      !(stall && redirect_ex));

   // the bubble behind a load clears the hazard
   single_stall: assert property (@(posedge clk) disable iff (rstn)
      stall |=> !stall);

endmodule

//--- hw/mem_access.sv
module mem_access #(
   parameter int RAM_ADDR_W = 19
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  core_pkg::ex_result_t  ex,
   input  logic                  ex_valid,
   input  core_pkg::ex_result_t  mem_stage,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output core_pkg::word_t       ram_din,
   output logic                  ram_we,
   output logic                  ram_en,
   input  core_pkg::word_t       ram_dout,
   output core_pkg::word_t       mem_value
);
   import core_pkg::*;

   logic is_load;
   logic is_store;

   assign is_load  = (ex.dec.kind == KIND_LOAD);
   assign is_store = (ex.dec.kind == KIND_STORE);

   // word address of the ram
   assign ram_addr = ex.result[RAM_ADDR_W+1:2];
   assign ram_din  = ex.store_data;
   assign ram_en   = ex_valid && (is_load || is_store);
   assign ram_we   = ex_valid && is_store;

   // read data lands while the load sits in the memory stage
   assign mem_value = (mem_stage.dec.kind == KIND_LOAD) ? ram_dout : mem_stage.result;

   we_needs_en: assert property (@(posedge clk) disable iff (rstn)
      ram_we |-> ram_en);

   read_lands_on_load: assert property (@(posedge clk) disable iff (rstn)
      (ram_en && !ram_we) |=> (mem_stage.dec.kind == KIND_LOAD));

endmodule

//--- hw/execute.sv
module execute (
   input  core_pkg::decoded_t   dec,
   input  core_pkg::operands_t  ops,
   output core_pkg::ex_result_t res
);
   import core_pkg::*;

   word_t      a;
   word_t      b;
   word_t      alu_out;
   word_t      link;
   logic [4:0] shamt;
   logic       cond_ok;

   // auipc adds to pc instead of rs1
   assign a     = (dec.kind == KIND_AUIPC) ? dec.pc : ops.rs1;
   assign b     = dec.b_is_imm ? dec.imm : ops.rs2;
   assign shamt = b[4:0];
   assign link  = dec.pc + 32'd4;

   ////////////////////////////////////////
   // alu
   ////////////////////////////////////////

   always_comb begin
      case (dec.alu_op)
         ALU_ADD:    alu_out = a + b;
         ALU_SUB:    alu_out = a - b;
         ALU_SLL:    alu_out = a << shamt;
         ALU_SLT:    alu_out = {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU:   alu_out = {31'b0, a < b};
         ALU_XOR:    alu_out = a ^ b;
         ALU_SRL:    alu_out = a >> shamt;
         ALU_SRA:    alu_out = word_t'($signed(a) >>> shamt);
         ALU_OR:     alu_out = a | b;
         ALU_AND:    alu_out = a & b;
         ALU_PASS_B: alu_out = b;
         default:    alu_out = '0;
      endcase
   end

   // branch compare
   always_comb begin
      case (dec.cond)
         COND_BEQ:  cond_ok = (ops.rs1 == ops.rs2);
         COND_BNE:  cond_ok = (ops.rs1 != ops.rs2);
         COND_BLT:  cond_ok = ($signed(ops.rs1) < $signed(ops.rs2));
         COND_BGE:  cond_ok = ($signed(ops.rs1) >= $signed(ops.rs2));
         COND_BLTU: cond_ok = (ops.rs1 < ops.rs2);
         COND_BGEU: cond_ok = (ops.rs1 >= ops.rs2);
         default:   cond_ok = 1'b0;
      endcase
   end

   always_comb begin
      res.dec        = dec;
      res.store_data = ops.rs2;
      res.taken      = (dec.kind == KIND_BRANCH) && cond_ok;
      if (dec.kind == KIND_JAL || dec.kind == KIND_JALR) begin
         res.result = link;
      end else begin
         res.result = alu_out;
      end
      if (dec.kind == KIND_JALR) begin
         res.target = (ops.rs1 + dec.imm) & ~32'd1;
      end else begin
         res.target = dec.pc + dec.imm;
      end
   end

endmodule

//--- hw/regfile.sv
module regfile (
   input  logic               clk,
   input  logic               rstn,
   input  core_pkg::reg_addr_t rs1,
   input  core_pkg::reg_addr_t rs2,
   output core_pkg::word_t    rd1,
   output core_pkg::word_t    rd2,
   input  logic               we,
   input  core_pkg::reg_addr_t wa,
   input  core_pkg::word_t    wd
);
   import core_pkg::*;

   word_t regs [32];

   // same-cycle write is visible to decode
   assign rd1 = (we && wa != '0 && wa == rs1) ? wd : regs[rs1];
   assign rd2 = (we && wa != '0 && wa == rs2) ? wd : regs[rs2];

   // x0 cleared by reset and never written
   always_ff @(posedge clk) begin
      if (rstn) begin
         regs[0] <= '0;
      end else if (we && wa != '0) begin
         regs[wa] <= wd;
      end
   end

   zero_reads_zero: assert property (@(posedge clk) disable iff (rstn)
      (rs1 != '0 || rd1 == '0) && (rs2 != '0 || rd2 == '0));

endmodule

//--- hw/decoder.sv
module decoder (
   input  core_pkg::word_t    pc,
   input  core_pkg::word_t    instr_raw,
   output core_pkg::decoded_t dec
);
   import core_pkg::*;

   instr_fields_t f;
   word_t         imm_i;
   word_t         imm_s;
   word_t         imm_b;
   word_t         imm_u;
   word_t         imm_j;
   logic          f7_zero;
   logic          f7_alt;

   // alt selects sub or sra
   function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
      alu_op_e op;
      case (f3)
         3'b000:  op = alt ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SLL;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLTU;
         3'b100:  op = ALU_XOR;
         3'b101:  op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   assign f = instr_raw;

   assign imm_i = {{20{instr_raw[31]}}, instr_raw[31:20]};
   assign imm_s = {{20{instr_raw[31]}}, instr_raw[31:25], instr_raw[11:7]};
   assign imm_b = {{19{instr_raw[31]}}, instr_raw[31], instr_raw[7],
                   instr_raw[30:25], instr_raw[11:8], 1'b0};
   assign imm_u = {instr_raw[31:12], 12'b0};
   assign imm_j = {{11{instr_raw[31]}}, instr_raw[31], instr_raw[19:12],
                   instr_raw[20], instr_raw[30:21], 1'b0};

   assign f7_zero = (f.funct7 == 7'b0000000);
   assign f7_alt  = (f.funct7 == 7'b0100000);

   always_comb begin
      dec        = '0;
      dec.pc     = pc;
      dec.kind   = KIND_ILLEGAL;
      dec.alu_op = ALU_ADD;
      dec.cond   = branch_cond_e'(f.funct3);
      dec.rs1    = f.rs1;
      dec.rs2    = f.rs2;
      dec.rd     = f.rd;
      case (f.opcode)
         OPC_LUI: begin
            dec.kind      = KIND_LUI;
            dec.alu_op    = ALU_PASS_B;
            dec.imm       = imm_u;
            dec.b_is_imm  = 1'b1;
            dec.writes_rd = 1'b1;
         end
         OPC_AUIPC: begin
            dec.kind      = KIND_AUIPC;
            dec.imm       = imm_u;
            dec.b_is_imm  = 1'b1;
            dec.writes_rd = 1'b1;
         end
         OPC_JAL: begin
            dec.kind      = KIND_JAL;
            dec.imm       = imm_j;
            dec.writes_rd = 1'b1;
         end
         OPC_JALR: begin
            if (f.funct3 == 3'b000) begin
               dec.kind      = KIND_JALR;
               dec.imm       = imm_i;
               dec.uses_rs1  = 1'b1;
               dec.writes_rd = 1'b1;
            end
         end
         OPC_BRANCH: begin
            // funct3 010 and 011 are unused
            if (f.funct3[2:1] != 2'b01) begin
               dec.kind     = KIND_BRANCH;
               dec.imm      = imm_b;
               dec.uses_rs1 = 1'b1;
               dec.uses_rs2 = 1'b1;
            end
         end
         OPC_LOAD: begin
            if (f.funct3 == 3'b010) begin
               dec.kind      = KIND_LOAD;
               dec.imm       = imm_i;
               dec.uses_rs1  = 1'b1;
               dec.b_is_imm  = 1'b1;
               dec.writes_rd = 1'b1;
            end
         end
         OPC_STORE: begin
            if (f.funct3 == 3'b010) begin
               dec.kind     = KIND_STORE;
               dec.imm      = imm_s;
               dec.uses_rs1 = 1'b1;
               dec.uses_rs2 = 1'b1;
               dec.b_is_imm = 1'b1;
            end
         end
         OPC_IMM: begin
            // shifts take their funct7 from the immediate
            if ((f.funct3 != 3'b001 && f.funct3 != 3'b101) || f7_zero ||
                (f.funct3 == 3'b101 && f7_alt)) begin
               dec.kind      = KIND_ALU;
               dec.alu_op    = alu_from_f3(f.funct3, f.funct3 == 3'b101 && f7_alt);
               dec.imm       = imm_i;
               dec.uses_rs1  = 1'b1;
               dec.b_is_imm  = 1'b1;
               dec.writes_rd = 1'b1;
            end
         end
         OPC_REG: begin
            if (f7_zero || (f7_alt && (f.funct3 == 3'b000 || f.funct3 == 3'b101))) begin
               dec.kind      = KIND_ALU;
               dec.alu_op    = alu_from_f3(f.funct3, f7_alt);
               dec.uses_rs1  = 1'b1;
               dec.uses_rs2  = 1'b1;
               dec.writes_rd = 1'b1;
            end
         end
         default: begin
            dec.kind = KIND_ILLEGAL;
         end
      endcase
      // x0 is never a destination
      dec.writes_rd = dec.writes_rd && (f.rd != '0);
   end

endmodule

//--- hw/core_pkg.sv
package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   ////////////////////////////////////////
   // instruction encoding
   ////////////////////////////////////////

   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_IMM    = 7'b0010011,
      OPC_REG    = 7'b0110011
   } opcode_e;

   // field positions of the R format, shared by all formats
   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      opcode_e    opcode;
   } instr_fields_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [3:0] {
      KIND_ALU,
      KIND_LUI,
      KIND_AUIPC,
      KIND_JAL,
      KIND_JALR,
      KIND_BRANCH,
      KIND_LOAD,
      KIND_STORE,
      KIND_ILLEGAL
   } op_kind_e;

   // values match funct3 of the branch format
   typedef enum logic [2:0] {
      COND_BEQ  = 3'b000,
      COND_BNE  = 3'b001,
      COND_BLT  = 3'b100,
      COND_BGE  = 3'b101,
      COND_BLTU = 3'b110,
      COND_BGEU = 3'b111
   } branch_cond_e;

   typedef enum logic [1:0] {
      FWD_RF,
      FWD_EX,
      FWD_MEM
   } fwd_sel_e;

   ////////////////////////////////////////
   // pipeline records
   ////////////////////////////////////////

   typedef struct packed {
      word_t        pc;
      op_kind_e     kind;
      alu_op_e      alu_op;
      branch_cond_e cond;
      reg_addr_t    rs1;
      reg_addr_t    rs2;
      reg_addr_t    rd;
      word_t        imm;
      logic         uses_rs1;
      logic         uses_rs2;
      logic         writes_rd;
      logic         b_is_imm;
   } decoded_t;

   typedef struct packed {
      word_t rs1;
      word_t rs2;
   } operands_t;

   typedef struct packed {
      decoded_t dec;
      word_t    result;
      word_t    store_data;
      logic     taken;
      word_t    target;
   } ex_result_t;

endpackage
